// ==== verilog/anb_pkg.sv ====
package anb_pkg;

    // ----------------------------------------------------------
    // Default bus geometry
    // ----------------------------------------------------------

    // Bus width in bytes
    parameter int DATA_BYTES = 16;

    // One data unit in bytes, four 32-bit units per word
    parameter int SPAN_BYTES = 4;

    // Largest offset plus one, in units
    // Must not exceed the units per word
    parameter int MAX_OFFSET = 4;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------

    // Unaligner FSM states
    // WAIT covers idle and the first word, TAIL is the extra last word
    typedef enum logic [1:0] {
        WAIT,
        RUN,
        TAIL
    } unalign_state_t;

    // Bus word, offset and last word length at the default geometry
    typedef logic [DATA_BYTES*8-1:0] anb_word_t;
    typedef logic [$clog2(MAX_OFFSET)-1:0] anb_offset_t;
    // Zero length means a full word
    typedef logic [$clog2(DATA_BYTES/SPAN_BYTES)-1:0] anb_len_t;

endpackage

// ==== verilog/unalign_ctrl.sv ====
`timescale 1ns/1ps

module unalign_ctrl #(
    parameter int DATA_W     = 16,
    parameter int SPAN       = 4,
    parameter int MAX_OFFSET = 4,
    localparam int OFFSET_W  = $clog2(MAX_OFFSET),
    localparam int LEN_W     = $clog2(DATA_W / SPAN)
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic                    in_last,
    input  logic                    out_ready,
    input  logic [OFFSET_W-1:0]     offset,
    input  logic [LEN_W-1:0]        len,
    output logic                    in_ready,
    output logic                    out_valid,
    output logic                    out_last,
    output logic                    load_carry,
    output anb_pkg::unalign_state_t state,
    output logic [OFFSET_W-1:0]     offset_reg,
    output logic [OFFSET_W-1:0]     carry_offset
);

    import anb_pkg::*;

    // Units per bus word
    localparam int WORD_UNITS = DATA_W / SPAN;
    // Tail count reaches offset plus a full word
    localparam int TAIL_W     = $clog2(WORD_UNITS + MAX_OFFSET);

    unalign_state_t    state_nxt;
    logic [TAIL_W-1:0] tail_count;
    logic [TAIL_W-1:0] first_tail;
    logic              first_no_fit;
    logic              run_no_fit;

    // Units in the last input word, zero length means full word
    function automatic logic [TAIL_W-1:0] last_word_len(input logic [LEN_W-1:0] l);
        return (l == '0) ? TAIL_W'(WORD_UNITS) : TAIL_W'(l);
    endfunction

    // ----------------------------------------------------------
    // Tail accounting
    // ----------------------------------------------------------

    // Units that land in the last output word, seen on the first word
    assign first_tail   = TAIL_W'(offset) + last_word_len(len);
    assign first_no_fit = first_tail > TAIL_W'(WORD_UNITS);
    // Same check against the count held for the transaction
    assign run_no_fit   = tail_count > TAIL_W'(WORD_UNITS);

    // Offset and tail count captured with the first word
    // Held for the middle words and the tail
    always_ff @(posedge clk) begin
        if (state == WAIT && in_valid) begin
            offset_reg <= offset;
            tail_count <= first_tail;
        end
    end

    // ----------------------------------------------------------
    // Handshake and last
    // ----------------------------------------------------------

    always_comb begin
        // Straight through by default
        in_ready  = out_ready;
        out_valid = in_valid;
        out_last  = in_last;
        case (state)
            WAIT: begin
                // Single word whose shifted units spill over
                if (first_no_fit) begin
                    out_last = 1'b0;
                end
            end
            RUN: begin
                // Last input word still leaves carried units
                if (run_no_fit) begin
                    out_last = 1'b0;
                end
            end
            TAIL: begin
                // Extra word from the carry, input stalled
                in_ready  = 1'b0;
                out_valid = 1'b1;
                out_last  = 1'b1;
            end
            default: begin
                out_last = in_last;
            end
        endcase
    end

    // Input word accepted
    assign load_carry   = in_valid & in_ready;
    // Live offset on the first word, held one afterwards
    assign carry_offset = (state == WAIT) ? offset : offset_reg;

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            WAIT: begin
                // Zero offset passes whole transactions through in WAIT
                if (load_carry && offset != '0) begin
                    if (!in_last) begin
                        state_nxt = RUN;
                    end else if (first_no_fit) begin
                        state_nxt = TAIL;
                    end
                end
            end
            RUN: begin
                if (load_carry && in_last) begin
                    state_nxt = run_no_fit ? TAIL : WAIT;
                end
            end
            TAIL: begin
                // One output cycle, leaves once the sink takes it
                if (out_ready) begin
                    state_nxt = WAIT;
                end
            end
            default: begin
                state_nxt = WAIT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= WAIT;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== verilog/unit_carry.sv ====
`timescale 1ns/1ps

module unit_carry #(
    parameter int DATA_W     = 16,
    parameter int SPAN       = 4,
    parameter int MAX_OFFSET = 4,
    localparam int OFFSET_W  = $clog2(MAX_OFFSET),
    localparam int CARRY_W   = (MAX_OFFSET - 1) * SPAN * 8
) (
    input  logic                  clk,
    input  logic                  load_carry,
    input  logic [DATA_W*8-1:0]   in_data,
    input  logic [OFFSET_W-1:0]   carry_offset,
    output logic [CARRY_W-1:0]    carry_units
);

    localparam int UNIT_W     = SPAN * 8;
    localparam int WORD_UNITS = DATA_W / SPAN;

    // Input word moved down so its top units sit at lane 0
    logic [DATA_W*8-1:0] high_units;

    // ----------------------------------------------------------
    // Overflow slice
    // ----------------------------------------------------------

    // Top carry_offset units are the ones pushed past the word
    // Zero offset shifts everything out
    always_comb begin
        high_units = in_data >> ((WORD_UNITS - int'(carry_offset)) * UNIT_W);
    end

    // Only MAX_OFFSET-1 units can ever overflow
    // Kept while the input is stalled
    always_ff @(posedge clk) begin
        if (load_carry) begin
            carry_units <= high_units[CARRY_W-1:0];
        end
    end

endmodule

// ==== verilog/unit_merge.sv ====
`timescale 1ns/1ps

module unit_merge #(
    parameter int DATA_W     = 16,
    parameter int SPAN       = 4,
    parameter int MAX_OFFSET = 4,
    localparam int OFFSET_W  = $clog2(MAX_OFFSET),
    localparam int CARRY_W   = (MAX_OFFSET - 1) * SPAN * 8
) (
    input  anb_pkg::unalign_state_t state,
    input  logic [OFFSET_W-1:0]     offset,
    input  logic [OFFSET_W-1:0]     offset_reg,
    input  logic [CARRY_W-1:0]      carry_units,
    input  logic [DATA_W*8-1:0]     in_data,
    output logic [DATA_W*8-1:0]     out_data
);

    import anb_pkg::*;

    localparam int UNIT_W  = SPAN * 8;
    localparam int CARRY_N = MAX_OFFSET - 1;

    // Carried units below ofst, incoming units from ofst upward
    function automatic logic [DATA_W*8-1:0] merge_units(
        input logic [CARRY_W-1:0]  carry,
        input logic [DATA_W*8-1:0] word,
        input logic [OFFSET_W-1:0] ofst
    );
        logic [DATA_W*8-1:0] merged;
        merged = word << (int'(ofst) * UNIT_W);
        for (int i = 0; i < CARRY_N; i++) begin
            if (i < int'(ofst)) begin
                merged[i*UNIT_W +: UNIT_W] = carry[i*UNIT_W +: UNIT_W];
            end
        end
        return merged;
    endfunction

    // ----------------------------------------------------------
    // Output word select
    // ----------------------------------------------------------

    always_comb begin
        case (state)
            WAIT: begin
                // First word, nothing carried yet so low lanes are zero
                // Offset zero leaves in_data as is
                out_data = merge_units('0, in_data, offset);
            end
            RUN: begin
                out_data = merge_units(carry_units, in_data, offset_reg);
            end
            TAIL: begin
                // Leftover units only, upper lanes zero
                out_data                = '0;
                out_data[CARRY_W-1:0]   = carry_units;
            end
            default: begin
                out_data = in_data;
            end
        endcase
    end

endmodule

// ==== verilog/anb_unalign.sv ====
`timescale 1ns/1ps

module anb_unalign #(
    parameter int DATA_W     = anb_pkg::DATA_BYTES,
    parameter int SPAN       = anb_pkg::SPAN_BYTES,
    parameter int MAX_OFFSET = anb_pkg::MAX_OFFSET,
    localparam int OFFSET_W  = $clog2(MAX_OFFSET),
    localparam int LEN_W     = $clog2(DATA_W / SPAN)
) (
    input  logic                clk,
    input  logic                arst_n,
    // Input stream
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [DATA_W*8-1:0] in_data,
    input  logic                in_last,
    // Valid with the first word of a transaction
    input  logic [OFFSET_W-1:0] offset,
    input  logic [LEN_W-1:0]    len,
    // Output stream
    output logic                out_valid,
    input  logic                out_ready,
    output logic [DATA_W*8-1:0] out_data,
    output logic                out_last
);

    import anb_pkg::*;

    // Units that can spill into the next output word
    localparam int CARRY_W = (MAX_OFFSET - 1) * SPAN * 8;

    unalign_state_t      state;
    logic                load_carry;
    logic [OFFSET_W-1:0] offset_reg;
    logic [OFFSET_W-1:0] carry_offset;
    logic [CARRY_W-1:0]  carry_units;

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------

    unalign_ctrl #(
        .DATA_W     (DATA_W),
        .SPAN       (SPAN),
        .MAX_OFFSET (MAX_OFFSET)
    ) u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .out_ready    (out_ready),
        .offset       (offset),
        .len          (len),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .load_carry   (load_carry),
        .state        (state),
        .offset_reg   (offset_reg),
        .carry_offset (carry_offset)
    );

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------

    // High units of each accepted word
    unit_carry #(
        .DATA_W     (DATA_W),
        .SPAN       (SPAN),
        .MAX_OFFSET (MAX_OFFSET)
    ) u_carry (
        .clk          (clk),
        .load_carry   (load_carry),
        .in_data      (in_data),
        .carry_offset (carry_offset),
        .carry_units  (carry_units)
    );

    unit_merge #(
        .DATA_W     (DATA_W),
        .SPAN       (SPAN),
        .MAX_OFFSET (MAX_OFFSET)
    ) u_merge (
        .state       (state),
        .offset      (offset),
        .offset_reg  (offset_reg),
        .carry_units (carry_units),
        .in_data     (in_data),
        .out_data    (out_data)
    );

endmodule

// ==== tb/tb_anb_unalign.sv ====
`timescale 1ns/1ps

module tb_anb_unalign;

    import anb_pkg::*;

    localparam int UNIT_BITS = SPAN_BYTES * 8;
    localparam int UNITS     = DATA_BYTES / SPAN_BYTES;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    anb_word_t   in_data;
    logic        in_last;
    anb_offset_t offset;
    anb_len_t    len;
    logic        out_valid;
    logic        out_ready;
    anb_word_t   out_data;
    logic        out_last;

    // Expected output words with one entry per output handshake
    anb_word_t exp_data[$];
    anb_word_t exp_mask[$];
    logic      exp_last[$];
    // Set on the extra word that has no input word of its own
    bit        exp_tail[$];

    string test_name    = "reset";
    bit    ready_random = 1'b0;
    int    errors       = 0;
    int    test_errors  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    out_count    = 0;
    int    cycles       = 0;
    // Grows with every queued transaction
    int    limit        = 100;

    anb_unalign dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_last   (in_last),
        .offset    (offset),
        .len       (len),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    // ----------------------------------------------------------
    // Clock, sink ready and cycle limit
    // ----------------------------------------------------------

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Sink always ready in directed tests and random under back-pressure
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = ready_random ? ($urandom % 2 == 0) : 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles in test %s, %0d output words never came out",
                     cycles, test_name, exp_data.size());
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    // Unit list holds offset zeros and then the input units
    // The last input word adds only its len units
    // Cut into bus words with the last flag on the final word only
    function automatic int expected_words(input anb_word_t words[$], input int off,
                                          input int l);
        logic [UNIT_BITS-1:0] units[$];
        anb_word_t            word;
        anb_word_t            mask;
        int                   last_len;
        int                   word_units;
        int                   n_out;
        int                   idx;
        last_len = (l == 0) ? UNITS : l;
        for (int i = 0; i < off; i++) begin
            units.push_back('0);
        end
        for (int w = 0; w < words.size(); w++) begin
            word_units = (w == words.size() - 1) ? last_len : UNITS;
            for (int u = 0; u < word_units; u++) begin
                units.push_back(words[w][u*UNIT_BITS +: UNIT_BITS]);
            end
        end
        n_out = (units.size() + UNITS - 1) / UNITS;
        for (int k = 0; k < n_out; k++) begin
            word = '0;
            mask = '0;
            for (int u = 0; u < UNITS; u++) begin
                idx = k * UNITS + u;
                // Lanes past the end of the unit list are don't care
                if (idx < units.size()) begin
                    word[u*UNIT_BITS +: UNIT_BITS] = units[idx];
                    mask[u*UNIT_BITS +: UNIT_BITS] = '1;
                end
            end
            exp_data.push_back(word);
            exp_mask.push_back(mask);
            exp_last.push_back(k == n_out - 1);
            exp_tail.push_back(k >= words.size());
        end
        return n_out;
    endfunction

    // Input follows the sink except while the extra tail word waits
    function automatic logic expected_ready(input logic sink_ready);
        if (exp_tail.size() != 0 && exp_tail[0]) begin
            return 1'b0;
        end
        return sink_ready;
    endfunction

    // ----------------------------------------------------------
    // Compare
    // ----------------------------------------------------------

    task automatic check_word(input string name, input anb_word_t exp, input anb_word_t act,
                              input anb_word_t mask);
        if ((act & mask) !== (exp & mask)) begin
            $display("error: test %s word %0d expected %h actual %h",
                     name, out_count, exp & mask, act & mask);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: test %s word %0d last expected %b actual %b",
                     name, out_count, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: test %s word %0d in_ready expected %b actual %b",
                     name, out_count, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // Every output handshake against the front of the expected list
    always @(posedge clk) begin
        if (arst_n) begin
            check_ready(test_name, expected_ready(out_ready), in_ready);
        end
        if (arst_n && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                $display("test %s put out an extra word that no input accounts for", test_name);
                errors++;
                test_errors++;
            end else begin
                check_word(test_name, exp_data.pop_front(), out_data, exp_mask.pop_front());
                check_last(test_name, exp_last.pop_front(), out_last);
                void'(exp_tail.pop_front());
            end
            out_count++;
        end
    end

    // ----------------------------------------------------------
    // Stimulus entered and left on a falling edge
    // ----------------------------------------------------------

    // Hold one word until the input handshake completes
    task automatic drive_word(input anb_word_t data, input logic last, input int off,
                              input int l, input bit gaps);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            in_valid = gaps ? ($urandom % 4 != 0) : 1'b1;
            in_data  = data;
            in_last  = last;
            offset   = anb_offset_t'(off);
            len      = anb_len_t'(l);
            @(posedge clk);
            taken = in_valid && in_ready;
            @(negedge clk);
        end
    endtask

    // Random payload with expected words queued before the first word goes in
    task automatic run_transaction(input int n, input int off, input int l, input bit gaps);
        anb_word_t words[$];
        anb_word_t data;
        int        n_out;
        for (int i = 0; i < n; i++) begin
            for (int u = 0; u < UNITS; u++) begin
                data[u*UNIT_BITS +: UNIT_BITS] = $urandom;
            end
            words.push_back(data);
        end
        n_out = expected_words(words, off, l);
        limit += 4 * (n + n_out);
        for (int i = 0; i < n; i++) begin
            drive_word(words[i], i == n - 1, off, l, gaps);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        out_count   = 0;
    endtask

    // Drain the expected list and idle a few cycles to catch extra words
    task automatic finish_test();
        in_valid = 1'b0;
        in_last  = 1'b0;
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d words out, %0d errors", test_name, out_count, test_errors);
    endtask

    initial begin
        void'($urandom(9356));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_last  = 1'b0;
        offset   = '0;
        len      = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("offset_zero");
        run_transaction(3, 0, 0, 1'b0);
        finish_test();

        // 1 + 2 units fit in the last word
        start_test("offset1_no_tail");
        run_transaction(3, 1, 2, 1'b0);
        finish_test();

        // Three units spill into an extra word
        start_test("offset3_tail");
        run_transaction(2, 3, 0, 1'b0);
        finish_test();

        start_test("single_word_tail");
        run_transaction(1, 2, 3, 1'b0);
        finish_test();

        // Back-pressure and input gaps with transactions back to back
        @(posedge clk);
        ready_random = 1'b1;
        @(negedge clk);
        start_test("random_backpressure");
        for (int t = 0; t < 50; t++) begin
            run_transaction(int'($urandom % 5) + 1, int'($urandom % MAX_OFFSET),
                            int'($urandom % UNITS), 1'b1);
        end
        finish_test();

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/anb_pkg.sv
verilog/unalign_ctrl.sv
verilog/unit_carry.sv
verilog/unit_merge.sv
verilog/anb_unalign.sv
tb/tb_anb_unalign.sv

// ==== Makefile ====
TOP := tb_anb_unalign

.PHONY: sim clean

# Build and run, then fail if the log holds the fail message
sim:
	verilator --binary --timing -j 0 --top-module $(TOP) --Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "Verification failed" sim.log

clean:
	rm -rf obj_dir sim.log
